// File: compile.f
opl_env_pkg.sv
op_step_if.sv
op_state_mem.sv
slot_sequencer.sv
env_rate_counter.sv
env_level_tracker.sv
opl_env_top.sv
tb_opl_env_assertions.sv
tb_opl_env.sv

// File: env_level_tracker.sv
// Per-slot attenuation level, raised by each overflow count.
// An overflow at cycle M yields the new level on the outputs at M+2.
`timescale 1ns/1ns

module env_level_tracker
    import opl_env_pkg::*;
#(
    parameter int NUM_BANKS    = opl_env_pkg::NUM_BANKS,
    parameter int OPS_PER_BANK = opl_env_pkg::OPS_PER_BANK
) (
    input  logic              clk,
    input  logic              rst_n,
    op_ovf_if.receiver        ovf,
    output logic              level_valid,
    output logic [BANK_W-1:0] level_bank,
    output logic [OP_W-1:0]   level_op,
    output level_t            level
);
    // ============================================================
    // Stage 1: add the overflow to the stored level
    // ============================================================

    logic              valid_p1;
    logic [BANK_W-1:0] bank_p1;
    logic [OP_W-1:0]   op_p1;
    overflow_t         count_p1;
    level_t            level_p1;
    logic [LEVEL_W:0]  sum_p1;
    level_t            sat_p1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_p1 <= 1'b0;
        end else begin
            valid_p1 <= ovf.ovf_valid;
        end
    end

    always_ff @(posedge clk) begin
        bank_p1  <= ovf.ovf_bank;
        op_p1    <= ovf.ovf_op;
        count_p1 <= ovf.ovf_count;
    end

    // One extra bit catches the carry, which then pins the level at the top.
    assign sum_p1 = (LEVEL_W + 1)'(level_p1) + (LEVEL_W + 1)'(count_p1);
    assign sat_p1 = (sum_p1 > LEVEL_MAX) ? LEVEL_MAX : sum_p1[LEVEL_W-1:0];

    // ============================================================
    // Stage 2: write back and present
    // ============================================================

    logic              valid_p2;
    logic [BANK_W-1:0] bank_p2;
    logic [OP_W-1:0]   op_p2;
    level_t            level_p2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_p2 <= 1'b0;
        end else begin
            valid_p2 <= valid_p1;
        end
    end

    always_ff @(posedge clk) begin
        bank_p2  <= bank_p1;
        op_p2    <= op_p1;
        level_p2 <= sat_p1;
    end

    // The same register feeds the memory and the outputs, so they agree.
    op_state_mem #(
        .T            (level_t),
        .NUM_BANKS    (NUM_BANKS),
        .OPS_PER_BANK (OPS_PER_BANK)
    ) i_level_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (valid_p2),
        .wr_bank (bank_p2),
        .wr_op   (op_p2),
        .wr_data (level_p2),
        .rd_en   (ovf.ovf_valid),
        .rd_bank (ovf.ovf_bank),
        .rd_op   (ovf.ovf_op),
        .rd_data (level_p1)
    );

    assign level_valid = valid_p2;
    assign level_bank  = bank_p2;
    assign level_op    = op_p2;
    assign level       = level_p2;
endmodule

// File: env_rate_counter.sv
// Effective envelope rate and per-slot rate accumulator.
// A step at cycle N yields the slot's overflow count at N+2.
`timescale 1ns/1ns

module env_rate_counter
    import opl_env_pkg::*;
#(
    parameter int NUM_BANKS    = opl_env_pkg::NUM_BANKS,
    parameter int OPS_PER_BANK = opl_env_pkg::OPS_PER_BANK
) (
    input  logic         clk,
    input  logic         rst_n,
    op_step_if.receiver  step,
    op_ovf_if.sender     ovf
);
    localparam int EFF_W = $clog2(EFF_RATE_MAX + 1);
    // Wide enough for a full counter plus 7 shifted left by 15.
    localparam int SUM_W = COUNTER_W + OVF_W;

    // ============================================================
    // Stage 0: key scaling and effective rate
    // ============================================================

    logic             split_bit;
    logic [3:0]       ks_raw;
    logic [3:0]       ks_term;
    logic [EFF_W:0]   eff_sum;
    logic [EFF_W-1:0] eff_rate;

    // The keyboard split picks which fnum bit refines the octave.
    assign split_bit = step.nts ? step.fnum[8] : step.fnum[9];

    // Block shifted left by one, with the split bit in the low position.
    assign ks_raw = {step.block, split_bit};

    // Without key scale rate only the top two bits of the term survive.
    assign ks_term = step.ksr ? ks_raw : (ks_raw >> 2);

    assign eff_sum  = (EFF_W + 1)'(ks_term) + (EFF_W + 1)'({step.rate, 2'b00});
    assign eff_rate = (eff_sum > EFF_RATE_MAX) ? EFF_W'(EFF_RATE_MAX) : eff_sum[EFF_W-1:0];

    // ============================================================
    // Stage 1: accumulate
    // ============================================================

    logic              valid_p1;
    logic              nz_p1;
    logic [BANK_W-1:0] bank_p1;
    logic [OP_W-1:0]   op_p1;
    logic [EFF_W-1:0]  eff_rate_p1;
    counter_t          counter_p1;
    logic [SUM_W-1:0]  sum_p1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_p1 <= 1'b0;
            nz_p1    <= 1'b0;
        end else begin
            valid_p1 <= step.step_valid;
            nz_p1    <= (step.rate != '0);
        end
    end

    always_ff @(posedge clk) begin
        bank_p1     <= step.bank;
        op_p1       <= step.op;
        eff_rate_p1 <= eff_rate;
    end

    // The low two rate bits set the increment mantissa, the rest the shift.
    assign sum_p1 = SUM_W'(counter_p1) +
                    (SUM_W'({1'b1, eff_rate_p1[1:0]}) << eff_rate_p1[EFF_W-1:2]);

    // ============================================================
    // Stage 2: overflow out and counter write-back
    // ============================================================

    logic              valid_p2;
    logic              nz_p2;
    logic [BANK_W-1:0] bank_p2;
    logic [OP_W-1:0]   op_p2;
    overflow_t         ovf_p2;
    counter_t          counter_p2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_p2 <= 1'b0;
            nz_p2    <= 1'b0;
        end else begin
            valid_p2 <= valid_p1;
            nz_p2    <= nz_p1;
        end
    end

    always_ff @(posedge clk) begin
        bank_p2    <= bank_p1;
        op_p2      <= op_p1;
        ovf_p2     <= overflow_t'(sum_p1 >> COUNTER_W);
        counter_p2 <= counter_t'(sum_p1);
    end

    // A slot with rate zero keeps its stored counter.
    op_state_mem #(
        .T            (counter_t),
        .NUM_BANKS    (NUM_BANKS),
        .OPS_PER_BANK (OPS_PER_BANK)
    ) i_counter_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (valid_p2 && nz_p2),
        .wr_bank (bank_p2),
        .wr_op   (op_p2),
        .wr_data (counter_p2),
        .rd_en   (step.step_valid),
        .rd_bank (step.bank),
        .rd_op   (step.op),
        .rd_data (counter_p1)
    );

    assign ovf.ovf_valid = valid_p2;
    assign ovf.ovf_bank  = bank_p2;
    assign ovf.ovf_op    = op_p2;
    assign ovf.ovf_count = ovf_p2;
endmodule

// File: op_state_mem.sv
// Per-slot state storage, one entry per bank and operator.
// Writes take effect at the clock edge. Reads return one cycle after rd_en.
`timescale 1ns/1ns

module op_state_mem
    import opl_env_pkg::*;
#(
    parameter type T            = counter_t,
    parameter int  NUM_BANKS    = opl_env_pkg::NUM_BANKS,
    parameter int  OPS_PER_BANK = opl_env_pkg::OPS_PER_BANK
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              we,
    input  logic [BANK_W-1:0] wr_bank,
    input  logic [OP_W-1:0]   wr_op,
    input  T                  wr_data,
    input  logic              rd_en,
    input  logic [BANK_W-1:0] rd_bank,
    input  logic [OP_W-1:0]   rd_op,
    output T                  rd_data
);
    localparam int DEPTH = NUM_BANKS * OPS_PER_BANK;

    // Banks are laid out one after another in a flat array.
    function automatic int unsigned slot_index(input logic [BANK_W-1:0] b,
                                               input logic [OP_W-1:0] o);
        return int'(b) * OPS_PER_BANK + int'(o);
    endfunction

    T mem_q [DEPTH];

    // The whole array starts at zero so that every slot begins silent.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (we && slot_index(wr_bank, wr_op) < DEPTH) begin
            mem_q[slot_index(wr_bank, wr_op)] <= wr_data;
        end
    end

    // Registered read port. The output holds between reads.
    always_ff @(posedge clk) begin
        if (rd_en && slot_index(rd_bank, rd_op) < DEPTH) begin
            rd_data <= mem_q[slot_index(rd_bank, rd_op)];
        end
    end
endmodule

// File: op_step_if.sv
// Bundles that link the pipeline stages of the envelope rate stage.
// op_step_if goes from the slot sequencer to the rate counter, and
// op_ovf_if goes from the rate counter to the level tracker.
`timescale 1ns/1ns

interface op_step_if
    import opl_env_pkg::*;
();
    // One operator step. There is no back-pressure, so a valid step is
    // consumed in the cycle it appears.
    logic               step_valid;
    logic [BANK_W-1:0]  bank;
    logic [OP_W-1:0]    op;
    logic               ksr;
    logic               nts;
    logic [FNUM_W-1:0]  fnum;
    logic [BLOCK_W-1:0] block;
    logic [RATE_W-1:0]  rate;

    modport sender (output step_valid, bank, op, ksr, nts, fnum, block, rate);
    modport receiver (input step_valid, bank, op, ksr, nts, fnum, block, rate);
endinterface

interface op_ovf_if
    import opl_env_pkg::*;
();
    // Overflow count of one slot after its accumulator update.
    logic              ovf_valid;
    logic [BANK_W-1:0] ovf_bank;
    logic [OP_W-1:0]   ovf_op;
    overflow_t         ovf_count;

    modport sender (output ovf_valid, ovf_bank, ovf_op, ovf_count);
    modport receiver (input ovf_valid, ovf_bank, ovf_op, ovf_count);
endinterface

// File: opl_env_pkg.sv
// Shared widths, slot counts and payload types for the envelope rate stage.
// Every RTL file imports this package in its module or interface header.

package opl_env_pkg;

    // ============================================================
    // Slot geometry
    // ============================================================

    // Default bank count. The top level parameter of the same name uses it.
    localparam int NUM_BANKS = 2;

    // Default number of operator slots in each bank.
    localparam int OPS_PER_BANK = 18;

    // Address widths for the bank number and the operator number.
    localparam int BANK_W = 1;
    localparam int OP_W   = 5;

    // ============================================================
    // Operator settings
    // ============================================================

    // Frequency number, block and requested envelope rate widths.
    localparam int FNUM_W  = 10;
    localparam int BLOCK_W = 3;
    localparam int RATE_W  = 4;

    // ============================================================
    // Envelope state
    // ============================================================

    // Accumulator, overflow count and attenuation level widths.
    localparam int COUNTER_W = 15;
    localparam int OVF_W     = 3;
    localparam int LEVEL_W   = 9;

    // The per-slot rate accumulator word.
    typedef logic [COUNTER_W-1:0] counter_t;

    // Number of accumulator wraps in one step, 0 to 7.
    typedef logic [OVF_W-1:0] overflow_t;

    // Attenuation level. A larger value means a quieter operator.
    typedef logic [LEVEL_W-1:0] level_t;

    // The level saturates here and never wraps.
    localparam level_t LEVEL_MAX = 9'd511;

    // Upper clamp on the effective rate. It keeps the shift at or below 15.
    localparam int EFF_RATE_MAX = 60;

endpackage

// File: opl_env_top.sv
// Top level of the envelope rate stage, with plain ports only.
// Settings come in through cfg_we writes, and each sample pulse starts a
// sweep whose levels appear four cycles after each step.
`timescale 1ns/1ns

module opl_env_top
    import opl_env_pkg::*;
#(
    parameter int NUM_BANKS    = opl_env_pkg::NUM_BANKS,
    parameter int OPS_PER_BANK = opl_env_pkg::OPS_PER_BANK
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sample_clk_en,
    input  logic               cfg_we,
    input  logic [BANK_W-1:0]  cfg_bank,
    input  logic [OP_W-1:0]    cfg_op,
    input  logic               cfg_ksr,
    input  logic               cfg_nts,
    input  logic [FNUM_W-1:0]  cfg_fnum,
    input  logic [BLOCK_W-1:0] cfg_block,
    input  logic [RATE_W-1:0]  cfg_rate,
    output logic               level_valid,
    output logic [BANK_W-1:0]  level_bank,
    output logic [OP_W-1:0]    level_op,
    output level_t             level
);
    // The pipelines keep two writes in flight, so a slot must not come back
    // within three cycles of its own step.
    if (NUM_BANKS * OPS_PER_BANK < 3) begin : g_slot_check
        $error("opl_env_top needs at least 3 operator slots");
    end

    op_step_if step_bus ();
    op_ovf_if  ovf_bus ();

    slot_sequencer #(
        .NUM_BANKS    (NUM_BANKS),
        .OPS_PER_BANK (OPS_PER_BANK)
    ) i_slot_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .cfg_we        (cfg_we),
        .cfg_bank      (cfg_bank),
        .cfg_op        (cfg_op),
        .cfg_ksr       (cfg_ksr),
        .cfg_nts       (cfg_nts),
        .cfg_fnum      (cfg_fnum),
        .cfg_block     (cfg_block),
        .cfg_rate      (cfg_rate),
        .step          (step_bus.sender)
    );

    env_rate_counter #(
        .NUM_BANKS    (NUM_BANKS),
        .OPS_PER_BANK (OPS_PER_BANK)
    ) i_env_rate_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (step_bus.receiver),
        .ovf   (ovf_bus.sender)
    );

    env_level_tracker #(
        .NUM_BANKS    (NUM_BANKS),
        .OPS_PER_BANK (OPS_PER_BANK)
    ) i_env_level_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .ovf         (ovf_bus.receiver),
        .level_valid (level_valid),
        .level_bank  (level_bank),
        .level_op    (level_op),
        .level       (level)
    );
endmodule

// File: slot_sequencer.sv
// Holds the operator settings and sweeps every slot once per sample pulse.
// A step leaves on the cycle after the pulse and one slot follows per cycle.
`timescale 1ns/1ns

module slot_sequencer
    import opl_env_pkg::*;
#(
    parameter int NUM_BANKS    = opl_env_pkg::NUM_BANKS,
    parameter int OPS_PER_BANK = opl_env_pkg::OPS_PER_BANK
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sample_clk_en,
    input  logic               cfg_we,
    input  logic [BANK_W-1:0]  cfg_bank,
    input  logic [OP_W-1:0]    cfg_op,
    input  logic               cfg_ksr,
    input  logic               cfg_nts,
    input  logic [FNUM_W-1:0]  cfg_fnum,
    input  logic [BLOCK_W-1:0] cfg_block,
    input  logic [RATE_W-1:0]  cfg_rate,
    op_step_if.sender          step
);
    // ============================================================
    // Settings register file
    // ============================================================

    logic               ksr_q   [NUM_BANKS][OPS_PER_BANK];
    logic               nts_q   [NUM_BANKS][OPS_PER_BANK];
    logic [FNUM_W-1:0]  fnum_q  [NUM_BANKS][OPS_PER_BANK];
    logic [BLOCK_W-1:0] block_q [NUM_BANKS][OPS_PER_BANK];
    logic [RATE_W-1:0]  rate_q  [NUM_BANKS][OPS_PER_BANK];

    // A write to a slot outside the configured geometry is dropped.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int o = 0; o < OPS_PER_BANK; o++) begin
                    ksr_q[b][o]   <= 1'b0;
                    nts_q[b][o]   <= 1'b0;
                    fnum_q[b][o]  <= '0;
                    block_q[b][o] <= '0;
                    rate_q[b][o]  <= '0;
                end
            end
        end else if (cfg_we && cfg_bank < NUM_BANKS && cfg_op < OPS_PER_BANK) begin
            ksr_q[cfg_bank][cfg_op]   <= cfg_ksr;
            nts_q[cfg_bank][cfg_op]   <= cfg_nts;
            fnum_q[cfg_bank][cfg_op]  <= cfg_fnum;
            block_q[cfg_bank][cfg_op] <= cfg_block;
            rate_q[cfg_bank][cfg_op]  <= cfg_rate;
        end
    end

    // ============================================================
    // Sweep counter
    // ============================================================

    logic              busy_q;
    logic [BANK_W-1:0] bank_q;
    logic [OP_W-1:0]   op_q;
    logic              last_op;
    logic              last_bank;

    assign last_op   = (op_q == OP_W'(OPS_PER_BANK - 1));
    assign last_bank = (bank_q == BANK_W'(NUM_BANKS - 1));

    // A pulse only starts a sweep from idle. Pulses seen while busy are lost.
    // The counters rest at slot zero, so the first step needs no preload.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            bank_q <= '0;
            op_q   <= '0;
        end else if (!busy_q) begin
            busy_q <= sample_clk_en;
        end else if (last_op) begin
            op_q <= '0;
            if (last_bank) begin
                bank_q <= '0;
                busy_q <= 1'b0;
            end else begin
                bank_q <= bank_q + 1'b1;
            end
        end else begin
            op_q <= op_q + 1'b1;
        end
    end

    // The step carries the settings as they stand in the cycle it is issued.
    assign step.step_valid = busy_q;
    assign step.bank       = bank_q;
    assign step.op         = op_q;
    assign step.ksr        = ksr_q[bank_q][op_q];
    assign step.nts        = nts_q[bank_q][op_q];
    assign step.fnum       = fnum_q[bank_q][op_q];
    assign step.block      = block_q[bank_q][op_q];
    assign step.rate       = rate_q[bank_q][op_q];
endmodule

// File: tb_opl_env.sv
// Testbench for the envelope rate stage. It fills the operator settings from an
// LFSR, runs many sweeps, and checks every level beat against a model.
// Run it with the file list in the project root; tb_opl_env is the top.
`timescale 1ns/1ns

module tb_opl_env
    import opl_env_pkg::*;
();
    localparam int          SLOTS            = NUM_BANKS * OPS_PER_BANK;
    localparam int          NUM_SWEEPS       = 150;
    localparam int          WRITES_PER_SWEEP = 6;
    localparam int          RESET_CYCLES     = 8;
    localparam logic [31:0] SEED             = 32'ha91ac3bd;
    localparam logic [31:0] LFSR_TAPS        = 32'h80200003;
    // Each sweep takes its slots plus the pipeline latency and a few writes.
    // One extra sweep preloads the counter of the rate 0 slot.
    localparam int WATCHDOG_CYCLES = (NUM_SWEEPS + 1) * (SLOTS + 10 + WRITES_PER_SWEEP) +
                                     SLOTS + RESET_CYCLES + 100;
    // A slot pinned at rate 0 and a slot pinned at rate 15.
    localparam int ZERO_BANK = 0;
    localparam int ZERO_OP   = 3;
    localparam int SAT_BANK  = 1;
    localparam int SAT_OP    = 5;

    typedef struct {
        int bank;
        int op;
        int level;
        int cyc;
    } beat_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               sample_clk_en;
    logic               cfg_we;
    logic [BANK_W-1:0]  cfg_bank;
    logic [OP_W-1:0]    cfg_op;
    logic               cfg_ksr;
    logic               cfg_nts;
    logic [FNUM_W-1:0]  cfg_fnum;
    logic [BLOCK_W-1:0] cfg_block;
    logic [RATE_W-1:0]  cfg_rate;
    logic               level_valid;
    logic [BANK_W-1:0]  level_bank;
    logic [OP_W-1:0]    level_op;
    level_t             level;

    // Model state, one entry per slot.
    int m_ksr [NUM_BANKS][OPS_PER_BANK];
    int m_nts [NUM_BANKS][OPS_PER_BANK];
    int m_fnum [NUM_BANKS][OPS_PER_BANK];
    int m_block [NUM_BANKS][OPS_PER_BANK];
    int m_rate [NUM_BANKS][OPS_PER_BANK];
    int m_counter [NUM_BANKS][OPS_PER_BANK];
    int m_level [NUM_BANKS][OPS_PER_BANK];
    int last_seen [NUM_BANKS][OPS_PER_BANK];

    beat_t       exp_q [$];
    logic [31:0] lfsr_state      = SEED;
    int          cyc             = 0;
    int          error_count     = 0;
    int          beat_count      = 0;
    int          pulses_accepted = 0;

    opl_env_top #(
        .NUM_BANKS    (NUM_BANKS),
        .OPS_PER_BANK (OPS_PER_BANK)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .cfg_we        (cfg_we),
        .cfg_bank      (cfg_bank),
        .cfg_op        (cfg_op),
        .cfg_ksr       (cfg_ksr),
        .cfg_nts       (cfg_nts),
        .cfg_fnum      (cfg_fnum),
        .cfg_block     (cfg_block),
        .cfg_rate      (cfg_rate),
        .level_valid   (level_valid),
        .level_bank    (level_bank),
        .level_op      (level_op),
        .level         (level)
    );

    always #4 clk = ~clk;

    // Counts rising edges, so beat cycles can be compared with the pulse cycle.
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ============================================================
    // Random source and configuration writes
    // ============================================================

    // One step of a right-shifting Galois LFSR.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // Takes n bits from the LFSR, one step per bit.
    task automatic take_bits(input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Drives one write on the falling edge and mirrors it into the model.
    task automatic write_slot(input int b, input int o, input int ksr, input int nts,
                              input int fnum, input int block, input int rate);
        cfg_we    = 1'b1;
        cfg_bank  = BANK_W'(b);
        cfg_op    = OP_W'(o);
        cfg_ksr   = ksr[0];
        cfg_nts   = nts[0];
        cfg_fnum  = FNUM_W'(fnum);
        cfg_block = BLOCK_W'(block);
        cfg_rate  = RATE_W'(rate);
        m_ksr[b][o]   = ksr;
        m_nts[b][o]   = nts;
        m_fnum[b][o]  = fnum;
        m_block[b][o] = block;
        m_rate[b][o]  = rate;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    // Random settings for one slot. The two pinned slots keep their rates.
    // The rate 0 slot also keeps the largest key scale term, 15.
    task automatic write_random_slot(input int b, input int o);
        int unsigned ksr, nts, fnum, block, rate;
        take_bits(1, ksr);
        take_bits(1, nts);
        take_bits(FNUM_W, fnum);
        take_bits(BLOCK_W, block);
        take_bits(RATE_W, rate);
        if (b == ZERO_BANK && o == ZERO_OP) begin
            ksr   = 1;
            nts   = 0;
            fnum  = 512;
            block = 7;
            rate  = 0;
        end
        if (b == SAT_BANK && o == SAT_OP) rate = 15;
        write_slot(b, o, ksr, nts, fnum, block, rate);
    endtask

    // ============================================================
    // Model of one sweep
    // ============================================================

    // Steps every slot in sweep order and queues the level beat it must give.
    task automatic predict_sweep(input int pulse_cyc);
        int split, ks, eff, sum, ovf, lvl, idx;
        idx = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int o = 0; o < OPS_PER_BANK; o++) begin
                split = m_nts[b][o] ? (m_fnum[b][o] >> 8) & 1 : (m_fnum[b][o] >> 9) & 1;
                ks = (m_block[b][o] << 1) | split;
                if (m_ksr[b][o] == 0) ks = ks >> 2;
                eff = ks + 4 * m_rate[b][o];
                if (eff > EFF_RATE_MAX) eff = EFF_RATE_MAX;
                // Mantissa 4 to 7, shifted by the upper rate bits.
                sum = m_counter[b][o] + ((4 | (eff % 4)) << (eff / 4));
                ovf = sum / 32768;
                if (m_rate[b][o] != 0) m_counter[b][o] = sum % 32768;
                lvl = m_level[b][o] + ovf;
                if (lvl > int'(LEVEL_MAX)) lvl = int'(LEVEL_MAX);
                m_level[b][o] = lvl;
                exp_q.push_back('{b, o, lvl, pulse_cyc + 5 + idx});
                idx++;
            end
        end
    endtask

    // One accepted pulse, optionally a second pulse that lands mid-sweep,
    // then a wait until every predicted beat has been seen.
    task automatic run_sweep(input bit extra_pulse);
        int unsigned gap;
        sample_clk_en = 1'b1;
        predict_sweep(cyc);
        pulses_accepted++;
        @(negedge clk);
        sample_clk_en = 1'b0;
        if (extra_pulse) begin
            take_bits(5, gap);
            repeat (gap) @(negedge clk);
            sample_clk_en = 1'b1;
            @(negedge clk);
            sample_clk_en = 1'b0;
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // ============================================================
    // Output monitor
    // ============================================================

    always @(negedge clk) begin
        beat_t e;
        if (rst_n && level_valid) begin
            beat_count++;
            if (exp_q.size() == 0) begin
                $display("ERROR time=%0t a level beat came with no sweep running", $time);
                error_count++;
            end else begin
                e = exp_q.pop_front();
                if (level_bank !== BANK_W'(e.bank)) begin
                    $display("ERROR time=%0t level_bank got=%0d expected=%0d",
                             $time, level_bank, e.bank);
                    error_count++;
                end
                if (level_op !== OP_W'(e.op)) begin
                    $display("ERROR time=%0t level_op got=%0d expected=%0d",
                             $time, level_op, e.op);
                    error_count++;
                end
                if (level !== level_t'(e.level)) begin
                    $display("ERROR time=%0t level got=%0d expected=%0d (bank %0d op %0d)",
                             $time, level, e.level, e.bank, e.op);
                    error_count++;
                end
                if (cyc != e.cyc) begin
                    $display("ERROR time=%0t level_valid cycle got=%0d expected=%0d",
                             $time, cyc, e.cyc);
                    error_count++;
                end
                last_seen[e.bank][e.op] = int'(level);
            end
        end
    end

    // ============================================================
    // Watchdog and main sequence
    // ============================================================

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: the sweeps did not finish in time.");
        $display("test failed");
        $finish;
    end

    initial begin
        int unsigned b, o;
        rst_n         = 1'b0;
        sample_clk_en = 1'b0;
        cfg_we        = 1'b0;
        cfg_bank      = '0;
        cfg_op        = '0;
        cfg_ksr       = 1'b0;
        cfg_nts       = 1'b0;
        cfg_fnum      = '0;
        cfg_block     = '0;
        cfg_rate      = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            for (int j = 0; j < OPS_PER_BANK; j++) begin
                m_ksr[i][j]     = 0;
                m_nts[i][j]     = 0;
                m_fnum[i][j]    = 0;
                m_block[i][j]   = 0;
                m_rate[i][j]    = 0;
                m_counter[i][j] = 0;
                m_level[i][j]   = 0;
                last_seen[i][j] = -1;
            end
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // The first sweep runs on the all-zero settings left by reset.
        run_sweep(1'b0);

        // One sweep at rate 12 leaves the rate 0 slot's counter at 28672.
        write_slot(ZERO_BANK, ZERO_OP, 1, 0, 512, 1, 12);
        run_sweep(1'b0);

        for (int i = 0; i < NUM_BANKS; i++) begin
            for (int j = 0; j < OPS_PER_BANK; j++) begin
                write_random_slot(i, j);
            end
        end

        // Every third sweep also gets a pulse that must be ignored.
        for (int s = 0; s < NUM_SWEEPS - 1; s++) begin
            run_sweep(s % 3 == 1);
            for (int w = 0; w < WRITES_PER_SWEEP; w++) begin
                take_bits(BANK_W, b);
                take_bits(OP_W, o);
                write_random_slot(b % NUM_BANKS, o % OPS_PER_BANK);
            end
        end
        repeat (10) @(negedge clk);

        if (beat_count != pulses_accepted * SLOTS) begin
            $display("ERROR time=%0t beat count got=%0d expected=%0d",
                     $time, beat_count, pulses_accepted * SLOTS);
            error_count++;
        end
        // Four overflows per sweep bring the pinned slot to the top before the end.
        if (last_seen[SAT_BANK][SAT_OP] != int'(LEVEL_MAX)) begin
            $display("ERROR time=%0t level of rate 15 slot got=%0d expected=%0d",
                     $time, last_seen[SAT_BANK][SAT_OP], LEVEL_MAX);
            error_count++;
        end
        // The rate 0 slot adds 56 per step to a counter held at 28672.
        // A counter that were written back would wrap within 74 sweeps.
        if (last_seen[ZERO_BANK][ZERO_OP] != 0) begin
            $display("ERROR time=%0t level of rate 0 slot got=%0d expected=0",
                     $time, last_seen[ZERO_BANK][ZERO_OP]);
            error_count++;
        end

        $display("Sweeps=%0d beats=%0d errors=%0d", pulses_accepted, beat_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end
endmodule

// File: tb_opl_env_assertions.sv
// Concurrent checks on the output timing of the envelope rate stage.
// Bound to every opl_env_top instance by the bind statement at the end.
`timescale 1ns/1ns

module opl_env_assertions
    import opl_env_pkg::*;
#(
    parameter int NUM_BANKS    = opl_env_pkg::NUM_BANKS,
    parameter int OPS_PER_BANK = opl_env_pkg::OPS_PER_BANK
) (
    input logic              clk,
    input logic              rst_n,
    input logic              level_valid,
    input logic [BANK_W-1:0] level_bank,
    input logic [OP_W-1:0]   level_op,
    input level_t            level
);
    localparam int SLOTS = NUM_BANKS * OPS_PER_BANK;

    // Length of the current run of level_valid beats, not counting this cycle.
    int run_len_q;

    // Last level presented for each slot.
    level_t last_level_q [NUM_BANKS][OPS_PER_BANK];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_len_q <= 0;
        end else if (level_valid) begin
            run_len_q <= run_len_q + 1;
        end else begin
            run_len_q <= 0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int o = 0; o < OPS_PER_BANK; o++) begin
                    last_level_q[b][o] <= '0;
                end
            end
        end else if (level_valid) begin
            last_level_q[level_bank][level_op] <= level;
        end
    end

    // ============================================================
    // Properties
    // ============================================================

    // Any cycle that follows a reset edge shows no output beat.
    a_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !level_valid)
        else $error("level_valid is high right after a reset cycle");

    // A slot's level only grows. A sum past 511 that wrapped would show up as a drop.
    a_level_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        level_valid |-> (!$isunknown(level) &&
                         level >= last_level_q[level_bank][level_op]))
        else $error("level unknown or lower than the slot's previous level");

    // A run of beats never grows past one full sweep.
    a_run_not_too_long: assert property (@(posedge clk) disable iff (!rst_n)
        level_valid |-> run_len_q < SLOTS)
        else $error("level_valid run is longer than one sweep");

    // When a run ends it has covered exactly one sweep.
    a_run_complete: assert property (@(posedge clk) disable iff (!rst_n)
        (!level_valid && run_len_q != 0) |-> run_len_q == SLOTS)
        else $error("level_valid run ended before the sweep was complete");
endmodule

bind opl_env_top opl_env_assertions #(
    .NUM_BANKS    (NUM_BANKS),
    .OPS_PER_BANK (OPS_PER_BANK)
) i_opl_env_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .level_valid (level_valid),
    .level_bank  (level_bank),
    .level_op    (level_op),
    .level       (level)
);
